/* core_cfg_pkg.sv */
// core sizing constants and per-unit execution latencies
package core_cfg_pkg;

    // register file addressing
    localparam int REG_ADDR_W = 5;   // x0..x31

    // scoreboard sizing, one slot per issue credit
    localparam int SLOT_NUM    = 8;
    localparam int COMMIT_ID_W = $clog2(SLOT_NUM);   // 3 bits for 8 slots

    // countdown width in the exec block, must hold the longest latency
    localparam int LAT_W = 3;

    // cycles from dispatch edge to commit, per unit
    localparam logic [LAT_W-1:0] LAT_ALU = 3'd2;   // bypass alu op
    localparam logic [LAT_W-1:0] LAT_MUL = 3'd3;
    localparam logic [LAT_W-1:0] LAT_DIV = 3'd6;   // longest one
    localparam logic [LAT_W-1:0] LAT_CSR = 3'd1;

endpackage

/* issue_pkg.sv */
// instruction word union, opcodes, exec type, issue/dispatch/commit/forwarding structs
package issue_pkg;

    // rv32 major opcodes that reach the long-op path
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;   // m extension marker

    // bit 1 clear means the type may use the alu bypass
    typedef enum logic [1:0] {
        EXEC_ALU = 2'b00,
        EXEC_MUL = 2'b01,
        EXEC_DIV = 2'b10,
        EXEC_CSR = 2'b11
    } exec_type_e;

    // r-type view, used for OP and MUL/DIV
    typedef struct packed {
        logic [6:0]                        funct7;
        logic [core_cfg_pkg::REG_ADDR_W-1:0] rs2;
        logic [core_cfg_pkg::REG_ADDR_W-1:0] rs1;
        logic [2:0]                        funct3;
        logic [core_cfg_pkg::REG_ADDR_W-1:0] rd;
        logic [6:0]                        opcode;
    } r_fields_t;

    // i-type view, used for OP-IMM and CSR
    typedef struct packed {
        logic [11:0]                       imm12;
        logic [core_cfg_pkg::REG_ADDR_W-1:0] rs1;
        logic [2:0]                        funct3;
        logic [core_cfg_pkg::REG_ADDR_W-1:0] rd;
        logic [6:0]                        opcode;
    } i_fields_t;

    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
    } inst_word_u;

    // decoder -> scoreboard
    typedef struct packed {
        logic                              valid;
        logic [core_cfg_pkg::REG_ADDR_W-1:0] rd;
        logic [core_cfg_pkg::REG_ADDR_W-1:0] rs1;
        logic [core_cfg_pkg::REG_ADDR_W-1:0] rs2;
        logic                              rd_we;
        logic                              rs1_re;
        logic                              rs2_re;
        exec_type_e                        exec_type;
    } issue_req_t;

    // scoreboard -> exec
    typedef struct packed {
        logic                               valid;
        logic [core_cfg_pkg::COMMIT_ID_W-1:0] commit_id;
        logic [core_cfg_pkg::REG_ADDR_W-1:0]  rd;
        exec_type_e                         exec_type;
    } dispatch_t;

    // exec -> scoreboard and top output
    typedef struct packed {
        logic                               valid;
        logic [core_cfg_pkg::COMMIT_ID_W-1:0] commit_id;
        logic [core_cfg_pkg::REG_ADDR_W-1:0]  rd;
        exec_type_e                         exec_type;
    } commit_t;

    // operand forwarding, one flag per unit and source
    typedef struct packed {
        logic alu_op1;
        logic alu_op2;
        logic mul_op1;
        logic mul_op2;
        logic div_op1;
        logic div_op2;
        logic csr_op1;
    } fwd_flags_t;

endpackage

/* issue_decoder.sv */
// issue_decoder: holding register and instruction decode into an issue request
`timescale 1ns/1ps

module issue_decoder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  issue_pkg::inst_word_u  inst_i,
    input  logic                   inst_valid_i,
    output logic                   inst_ready_o,
    input  logic                   stall_i,
    output issue_pkg::issue_req_t  req_o
);

    issue_pkg::inst_word_u inst_q;   // held word
    logic                  valid_q;
    logic                  is_muldiv;

    // free slot, or the held request leaves this cycle
    assign inst_ready_o = !valid_q || !stall_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (inst_ready_o) begin
            valid_q <= inst_valid_i;   // load or drain
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid_i && inst_ready_o) begin
            inst_q <= inst_i;
        end
    end

    assign is_muldiv = (inst_q.r_fields.funct7 == issue_pkg::FUNCT7_MULDIV);

    always_comb begin
        req_o = '0;
        case (inst_q.r_fields.opcode)
            issue_pkg::OPC_OP: begin   // register-register, r view
                req_o.valid  = valid_q;
                req_o.rd     = inst_q.r_fields.rd;
                req_o.rs1    = inst_q.r_fields.rs1;
                req_o.rs2    = inst_q.r_fields.rs2;
                req_o.rd_we  = 1'b1;
                req_o.rs1_re = 1'b1;
                req_o.rs2_re = 1'b1;
                if (is_muldiv) begin
                    // funct3 0..3 mul family, 4..7 div/rem
                    req_o.exec_type = inst_q.r_fields.funct3[2] ? issue_pkg::EXEC_DIV
                                                                : issue_pkg::EXEC_MUL;
                end else begin
                    req_o.exec_type = issue_pkg::EXEC_ALU;
                end
            end
            issue_pkg::OPC_OP_IMM: begin   // immediate alu, i view
                req_o.valid     = valid_q;
                req_o.rd        = inst_q.i_fields.rd;
                req_o.rs1       = inst_q.i_fields.rs1;
                req_o.rd_we     = 1'b1;
                req_o.rs1_re    = 1'b1;
                req_o.exec_type = issue_pkg::EXEC_ALU;
            end
            issue_pkg::OPC_SYSTEM: begin
                // csr access reads rs1 only
                req_o.valid     = valid_q;
                req_o.rd        = inst_q.i_fields.rd;
                req_o.rs1       = inst_q.i_fields.rs1;
                req_o.rd_we     = 1'b1;
                req_o.rs1_re    = 1'b1;
                req_o.exec_type = issue_pkg::EXEC_CSR;
            end
            default: ;   // not a long op, request stays invalid and drains
        endcase
    end

endmodule

/* long_op_scoreboard.sv */
// long_op_scoreboard: in-flight slot table, raw/waw stall, id allocation, forwarding flags
`timescale 1ns/1ps

module long_op_scoreboard (
    input  logic                  clk,
    input  logic                  rst_n,
    input  issue_pkg::issue_req_t req_i,
    input  issue_pkg::commit_t    commit_i,
    output logic                  stall_o,
    output issue_pkg::dispatch_t  dispatch_o,
    output issue_pkg::fwd_flags_t fwd_o,
    output logic                  lock_o
);

    // slot table, the valid vector doubles as the credit pool
    logic [core_cfg_pkg::SLOT_NUM-1:0]   slot_valid_q;
    logic [core_cfg_pkg::REG_ADDR_W-1:0] slot_rd_q   [core_cfg_pkg::SLOT_NUM];
    issue_pkg::exec_type_e               slot_type_q [core_cfg_pkg::SLOT_NUM];

    // most recent alu writer, masked out of raw for bypass types
    logic [core_cfg_pkg::SLOT_NUM-1:0]    alu_mask_q;    // 0 bit = masked
    logic [core_cfg_pkg::COMMIT_ID_W-1:0] alu_mask_id_q;

    logic [core_cfg_pkg::SLOT_NUM-1:0] live;      // valid and not committing now
    logic [core_cfg_pkg::SLOT_NUM-1:0] rs1_vec;
    logic [core_cfg_pkg::SLOT_NUM-1:0] rs2_vec;
    logic [core_cfg_pkg::SLOT_NUM-1:0] raw_vec;
    logic [core_cfg_pkg::SLOT_NUM-1:0] waw_vec;
    logic                              raw_hit;
    logic                              waw_hit;
    logic                              full;
    logic                              accept;
    logic [core_cfg_pkg::COMMIT_ID_W-1:0] free_id;

    genvar g;
    generate
        for (g = 0; g < core_cfg_pkg::SLOT_NUM; g++) begin : g_slot
            // committing slot drops out of the checks in the same cycle
            assign live[g] = slot_valid_q[g] &&
                !(commit_i.valid && commit_i.commit_id == core_cfg_pkg::COMMIT_ID_W'(g));
            assign rs1_vec[g] = live[g] && req_i.rs1_re && (req_i.rs1 == slot_rd_q[g]);
            assign rs2_vec[g] = live[g] && req_i.rs2_re && (req_i.rs2 == slot_rd_q[g]);
            // same rd in the same unit retires in order, so no waw there
            assign waw_vec[g] = live[g] && req_i.rd_we && (req_i.rd == slot_rd_q[g]) &&
                                (slot_type_q[g] != req_i.exec_type);
        end
    endgenerate

    assign raw_vec = (rs1_vec | rs2_vec) &
                     (req_i.exec_type[1] ? '1 : alu_mask_q);   // bypassable types use mask
    assign raw_hit = |raw_vec;
    assign waw_hit = |waw_vec;
    assign full    = &slot_valid_q;   // no credit left

    assign stall_o = req_i.valid && (raw_hit || waw_hit || full);
    assign accept  = req_i.valid && !stall_o;

    // lowest free slot wins
    always_comb begin
        free_id = '0;
        for (int i = core_cfg_pkg::SLOT_NUM - 1; i >= 0; i--) begin
            if (!slot_valid_q[i]) begin
                free_id = core_cfg_pkg::COMMIT_ID_W'(i);
            end
        end
    end

    always_comb begin
        dispatch_o.valid     = accept;
        dispatch_o.commit_id = free_id;
        dispatch_o.rd        = req_i.rd;
        dispatch_o.exec_type = req_i.exec_type;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_valid_q <= '0;
        end else begin
            if (commit_i.valid) begin
                slot_valid_q[commit_i.commit_id] <= 1'b0;   // credit back
            end
            if (accept) begin
                slot_valid_q[free_id] <= 1'b1;   // never the committing slot
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            slot_rd_q[free_id]   <= req_i.rd;
            slot_type_q[free_id] <= req_i.exec_type;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_mask_q    <= '1;
            alu_mask_id_q <= '0;
        end else begin
            if (commit_i.valid && commit_i.commit_id == alu_mask_id_q) begin
                alu_mask_q <= '1;   // writer gone
            end
            // a new alu writer takes over the mask
            if (accept && req_i.exec_type == issue_pkg::EXEC_ALU && req_i.rd_we) begin
                alu_mask_q    <= ~(core_cfg_pkg::SLOT_NUM'(1) << free_id);
                alu_mask_id_q <= free_id;
            end
        end
    end

    // forwarding ignores the bypass mask
    always_comb begin
        fwd_o         = '0;
        fwd_o.alu_op1 = req_i.valid && req_i.exec_type == issue_pkg::EXEC_ALU && |rs1_vec;
        fwd_o.alu_op2 = req_i.valid && req_i.exec_type == issue_pkg::EXEC_ALU && |rs2_vec;
        fwd_o.mul_op1 = req_i.valid && req_i.exec_type == issue_pkg::EXEC_MUL && |rs1_vec;
        fwd_o.mul_op2 = req_i.valid && req_i.exec_type == issue_pkg::EXEC_MUL && |rs2_vec;
        fwd_o.div_op1 = req_i.valid && req_i.exec_type == issue_pkg::EXEC_DIV && |rs1_vec;
        fwd_o.div_op2 = req_i.valid && req_i.exec_type == issue_pkg::EXEC_DIV && |rs2_vec;
        fwd_o.csr_op1 = req_i.valid && req_i.exec_type == issue_pkg::EXEC_CSR && |rs1_vec;
    end

    assign lock_o = |slot_valid_q;   // anything still in flight

endmodule

/* long_op_exec.sv */
// long_op_exec: per-slot latency countdown and in-order-by-id commit emission
`timescale 1ns/1ps

module long_op_exec (
    input  logic                 clk,
    input  logic                 rst_n,
    input  issue_pkg::dispatch_t dispatch_i,
    output issue_pkg::commit_t   commit_o
);

    logic [core_cfg_pkg::SLOT_NUM-1:0]   busy_q;    // counting down
    logic [core_cfg_pkg::SLOT_NUM-1:0]   ready_q;   // finished, waiting to commit
    logic [core_cfg_pkg::LAT_W-1:0]      cnt_q  [core_cfg_pkg::SLOT_NUM];
    logic [core_cfg_pkg::REG_ADDR_W-1:0] rd_q   [core_cfg_pkg::SLOT_NUM];
    issue_pkg::exec_type_e               type_q [core_cfg_pkg::SLOT_NUM];
    logic [core_cfg_pkg::COMMIT_ID_W-1:0] sel_id;

    function automatic logic [core_cfg_pkg::LAT_W-1:0] lat_of(
        input issue_pkg::exec_type_e t
    );
        case (t)
            issue_pkg::EXEC_ALU: lat_of = core_cfg_pkg::LAT_ALU;
            issue_pkg::EXEC_MUL: lat_of = core_cfg_pkg::LAT_MUL;
            issue_pkg::EXEC_DIV: lat_of = core_cfg_pkg::LAT_DIV;
            default:             lat_of = core_cfg_pkg::LAT_CSR;
        endcase
    endfunction

    // lowest finished id first
    always_comb begin
        sel_id = '0;
        for (int i = core_cfg_pkg::SLOT_NUM - 1; i >= 0; i--) begin
            if (ready_q[i]) begin
                sel_id = core_cfg_pkg::COMMIT_ID_W'(i);
            end
        end
    end

    always_comb begin
        commit_o.valid     = |ready_q;
        commit_o.commit_id = sel_id;
        commit_o.rd        = rd_q[sel_id];
        commit_o.exec_type = type_q[sel_id];
    end

    // loaded at dispatch edge, ready lands exactly lat edges later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q  <= '0;
            ready_q <= '0;
            for (int i = 0; i < core_cfg_pkg::SLOT_NUM; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < core_cfg_pkg::SLOT_NUM; i++) begin
                if (dispatch_i.valid &&
                    dispatch_i.commit_id == core_cfg_pkg::COMMIT_ID_W'(i)) begin
                    busy_q[i] <= 1'b1;
                    cnt_q[i]  <= lat_of(dispatch_i.exec_type);
                end else if (busy_q[i]) begin
                    if (cnt_q[i] == core_cfg_pkg::LAT_W'(1)) begin
                        busy_q[i]  <= 1'b0;
                        ready_q[i] <= 1'b1;   // done, queue for commit
                    end else begin
                        cnt_q[i] <= cnt_q[i] - 1'b1;
                    end
                end
                if (commit_o.valid && sel_id == core_cfg_pkg::COMMIT_ID_W'(i)) begin
                    ready_q[i] <= 1'b0;   // emitted this cycle
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_i.valid) begin
            rd_q[dispatch_i.commit_id]   <= dispatch_i.rd;
            type_q[dispatch_i.commit_id] <= dispatch_i.exec_type;
        end
    end

endmodule

/* issue_top.sv */
// issue_top: decoder, scoreboard and exec block wired together
`timescale 1ns/1ps

module issue_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  issue_pkg::inst_word_u inst_i,
    input  logic                  inst_valid_i,
    output logic                  inst_ready_o,
    output logic                  stall_o,
    output issue_pkg::commit_t    commit_o,
    output issue_pkg::fwd_flags_t fwd_o,
    output logic                  lock_o
);

    issue_pkg::issue_req_t req;        // decoder -> scoreboard
    issue_pkg::dispatch_t  dispatch;   // scoreboard -> exec

    issue_decoder u_decoder (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_i       (inst_i),
        .inst_valid_i (inst_valid_i),
        .inst_ready_o (inst_ready_o),
        .stall_i      (stall_o),
        .req_o        (req)
    );

    long_op_scoreboard u_scoreboard (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_i      (req),
        .commit_i   (commit_o),   // commit also frees the credit
        .stall_o    (stall_o),
        .dispatch_o (dispatch),
        .fwd_o      (fwd_o),
        .lock_o     (lock_o)
    );

    long_op_exec u_exec (
        .clk        (clk),
        .rst_n      (rst_n),
        .dispatch_i (dispatch),
        .commit_o   (commit_o)
    );

endmodule

/* issue_assertions.sv */
// issue_assertions: concurrent checks on scoreboard dispatch and commit, bound into the scoreboard
`timescale 1ns/1ps

module issue_assertions (
    input logic                              clk,
    input logic                              rst_n,
    input logic                              stall_i,
    input issue_pkg::issue_req_t             req_i,
    input issue_pkg::dispatch_t              dispatch_i,
    input issue_pkg::commit_t                commit_i,
    input logic [core_cfg_pkg::SLOT_NUM-1:0] slot_valid_i
);

    // a stalled request is held unchanged until it leaves
    a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        stall_i |=> req_i.valid && $stable(req_i))
        else $error("stalled request changed or dropped");

    // allocation only picks a free credit
    a_dispatch_free_slot: assert property (@(posedge clk) disable iff (!rst_n)
        dispatch_i.valid |-> !slot_valid_i[dispatch_i.commit_id])
        else $error("dispatch into a busy slot");

    a_commit_valid_slot: assert property (@(posedge clk) disable iff (!rst_n)
        commit_i.valid |-> slot_valid_i[commit_i.commit_id])
        else $error("commit for an empty slot");   // returns a credit never taken

endmodule

bind long_op_scoreboard issue_assertions u_issue_assertions (
    .clk          (clk),
    .rst_n        (rst_n),
    .stall_i      (stall_o),
    .req_i        (req_i),
    .dispatch_i   (dispatch_o),
    .commit_i     (commit_i),
    .slot_valid_i (slot_valid_q)
);

/* tb_issue_top.sv */
// tb_issue_top: clock, reset, vector driver, in-flight reference model and compare tasks
`timescale 1ns/1ps

module tb_issue_top;

    localparam int VEC_NUM    = 17;
    localparam int HAZARD_NUM = 8;     // directed words, random gaps before each
    localparam int TIMEOUT    = 200;   // cycles per wait
    localparam int SLOTS      = core_cfg_pkg::SLOT_NUM;

    logic                  clk;
    logic                  rst_n;
    issue_pkg::inst_word_u inst_i;
    logic                  inst_valid_i;
    logic                  inst_ready_o;
    logic                  stall_o;
    logic                  lock_o;
    issue_pkg::commit_t    commit_o;
    issue_pkg::fwd_flags_t fwd_o;

    logic [35:0] vec_mem [VEC_NUM];   // {stall flag nibble, word}

    // reference in-flight table
    logic [SLOTS-1:0]                    m_valid;
    logic [core_cfg_pkg::REG_ADDR_W-1:0] m_rd   [SLOTS];
    issue_pkg::exec_type_e               m_type [SLOTS];
    int                                  m_cnt  [SLOTS];   // edges left until finished
    logic [SLOTS-1:0]                    m_ready;          // finished, commit pending
    logic                                mask_on;   // last alu writer bypassed
    logic [core_cfg_pkg::COMMIT_ID_W-1:0] mask_id;
    logic                                have_req;  // word sitting in the decoder
    issue_pkg::issue_req_t               cur_req;
    int                                  cur_idx;
    logic                                saw_stall;
    int hs_count;
    int disp_count;
    int commit_count;
    int val_errors;
    int other_errors;
    logic timed_out;
    int unsigned rnd;

    issue_top u_issue_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_i       (inst_i),
        .inst_valid_i (inst_valid_i),
        .inst_ready_o (inst_ready_o),
        .stall_o      (stall_o),
        .commit_o     (commit_o),
        .fwd_o        (fwd_o),
        .lock_o       (lock_o)
    );

    always #2 clk = ~clk;   // 4 ns period

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // cycles from the dispatch edge to the commit, per unit
    function automatic int unit_latency(input issue_pkg::exec_type_e t);
        case (t)
            issue_pkg::EXEC_ALU: return int'(core_cfg_pkg::LAT_ALU);
            issue_pkg::EXEC_MUL: return int'(core_cfg_pkg::LAT_MUL);
            issue_pkg::EXEC_DIV: return int'(core_cfg_pkg::LAT_DIV);
            default:             return int'(core_cfg_pkg::LAT_CSR);
        endcase
    endfunction

    // rv32 field layout, m extension marked by funct7 0000001
    function automatic issue_pkg::issue_req_t decode_word(input logic [31:0] w);
        issue_pkg::issue_req_t r;
        r        = '0;
        r.valid  = 1'b1;
        r.rd     = w[11:7];
        r.rs1    = w[19:15];
        r.rd_we  = 1'b1;
        r.rs1_re = 1'b1;
        if (w[6:0] == 7'b0110011) begin
            r.rs2    = w[24:20];
            r.rs2_re = 1'b1;
            if (w[31:25] == 7'b0000001) begin
                r.exec_type = (w[14:12] < 3'd4) ? issue_pkg::EXEC_MUL : issue_pkg::EXEC_DIV;
            end else begin
                r.exec_type = issue_pkg::EXEC_ALU;
            end
        end else if (w[6:0] == 7'b1110011) begin
            r.exec_type = issue_pkg::EXEC_CSR;   // csr reads rs1 only
        end else begin
            r.exec_type = issue_pkg::EXEC_ALU;   // op-imm
        end
        return r;
    endfunction

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("FAILED %s expected %b actual %b", name, exp, act);
            val_errors++;
        end
    endtask

    task automatic check_fwd(input string name, input issue_pkg::fwd_flags_t exp,
                             input issue_pkg::fwd_flags_t act);
        if (exp !== act) begin
            $display("FAILED %s expected %b actual %b", name, exp, act);
            val_errors++;
        end
    endtask

    task automatic check_commit(input string name, input issue_pkg::commit_t exp,
                                input issue_pkg::commit_t act);
        if (exp !== act) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            val_errors++;
        end
    endtask

    // one model step per edge, on pre-edge values
    task automatic step_model();
        logic [SLOTS-1:0]      live;
        logic [SLOTS-1:0]      hit1;
        logic [SLOTS-1:0]      hit2;
        logic [SLOTS-1:0]      raw;
        logic [SLOTS-1:0]      waw;
        logic                  exp_stall;
        issue_pkg::fwd_flags_t exp_fwd;
        issue_pkg::commit_t    exp_c;
        int                    free_id;
        int                    exp_id;
        for (int i = 0; i < SLOTS; i++) begin
            live[i] = m_valid[i] && !(commit_o.valid && commit_o.commit_id == 3'(i));
            hit1[i] = have_req && live[i] && cur_req.rs1_re && cur_req.rs1 == m_rd[i];
            hit2[i] = have_req && live[i] && cur_req.rs2_re && cur_req.rs2 == m_rd[i];
            waw[i]  = have_req && live[i] && cur_req.rd_we && cur_req.rd == m_rd[i] &&
                      m_type[i] != cur_req.exec_type;
            // bypassable types skip the last alu writer
            raw[i]  = (hit1[i] || hit2[i]) &&
                      !(!cur_req.exec_type[1] && mask_on && mask_id == 3'(i));
        end
        exp_stall = have_req && (|raw || |waw || &m_valid);
        exp_fwd   = '0;
        if (have_req) begin
            case (cur_req.exec_type)
                issue_pkg::EXEC_ALU: begin
                    exp_fwd.alu_op1 = |hit1;
                    exp_fwd.alu_op2 = |hit2;
                end
                issue_pkg::EXEC_MUL: begin
                    exp_fwd.mul_op1 = |hit1;
                    exp_fwd.mul_op2 = |hit2;
                end
                issue_pkg::EXEC_DIV: begin
                    exp_fwd.div_op1 = |hit1;
                    exp_fwd.div_op2 = |hit2;
                end
                default: exp_fwd.csr_op1 = |hit1;
            endcase
        end
        check_bit("stall_o", exp_stall, stall_o);
        check_bit("inst_ready_o", !have_req || !exp_stall, inst_ready_o);   // back-pressure
        check_bit("lock_o", |m_valid, lock_o);
        check_fwd("fwd_o", exp_fwd, fwd_o);
        if (have_req && stall_o) begin
            saw_stall = 1'b1;
        end
        // lowest free slot, taken from the table before this edge
        free_id = 0;
        for (int i = SLOTS - 1; i >= 0; i--) begin
            if (!m_valid[i]) begin
                free_id = i;
            end
        end
        // finished slots leave one per cycle, lowest id first
        exp_id = 0;
        for (int i = SLOTS - 1; i >= 0; i--) begin
            if (m_ready[i]) begin
                exp_id = i;
            end
        end
        if (|m_ready) begin
            exp_c.valid     = 1'b1;
            exp_c.commit_id = 3'(exp_id);
            exp_c.rd        = m_rd[exp_id];
            exp_c.exec_type = m_type[exp_id];
            check_commit("commit_o", exp_c, commit_o);
            m_ready[exp_id] = 1'b0;
        end else begin
            check_bit("commit_o.valid", 1'b0, commit_o.valid);
        end
        if (commit_o.valid) begin
            commit_count++;
            if (!m_valid[commit_o.commit_id]) begin
                $display("commit seen for slot %0d with nothing in flight", commit_o.commit_id);
                other_errors++;
            end
            m_valid[commit_o.commit_id] = 1'b0;   // credit back
            if (mask_on && mask_id == commit_o.commit_id) begin
                mask_on = 1'b0;
            end
        end
        for (int i = 0; i < SLOTS; i++) begin
            if (m_cnt[i] > 0) begin
                m_cnt[i]--;
                if (m_cnt[i] == 0) begin
                    m_ready[i] = 1'b1;   // finishes at this edge
                end
            end
        end
        if (have_req && !exp_stall) begin
            check_bit($sformatf("stall column word %0d", cur_idx), vec_mem[cur_idx][32],
                      saw_stall);
            m_valid[free_id] = 1'b1;
            m_rd[free_id]    = cur_req.rd;
            m_type[free_id]  = cur_req.exec_type;
            m_cnt[free_id]   = unit_latency(cur_req.exec_type);
            if (cur_req.exec_type == issue_pkg::EXEC_ALU && cur_req.rd_we) begin
                mask_on = 1'b1;   // newest alu writer wins
                mask_id = 3'(free_id);
            end
            disp_count++;
            have_req = 1'b0;
        end
        if (inst_valid_i && inst_ready_o) begin
            cur_req   = decode_word(inst_i);
            cur_idx   = hs_count;
            have_req  = 1'b1;
            saw_stall = 1'b0;
            hs_count++;
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            step_model();
        end
    end

    // drive one word and hold it until the decoder takes it
    task automatic send_word(input logic [31:0] w);
        int start;
        int cnt;
        start        = hs_count;
        cnt          = 0;
        inst_i       = w;
        inst_valid_i = 1'b1;
        while (hs_count == start && cnt < TIMEOUT) begin
            @(posedge clk);
            #0.5;
            cnt++;
        end
        if (hs_count == start) begin
            $display("timeout: word %0d never accepted by the decoder", start);
            timed_out = 1'b1;
        end
        inst_valid_i = 1'b0;
    endtask

    // everything issued has committed and the table is empty
    task automatic wait_drain();
        int cnt;
        cnt = 0;
        while ((lock_o || have_req || |m_valid) && cnt < TIMEOUT) begin
            @(posedge clk);
            #0.5;
            cnt++;
        end
        if (lock_o || have_req || |m_valid) begin
            $display("timeout: in-flight instructions did not drain");
            timed_out = 1'b1;
        end
    endtask

    initial begin
        int gap;
        clk          = 1'b0;
        rst_n        = 1'b0;
        inst_i       = '0;
        inst_valid_i = 1'b0;
        m_valid      = '0;
        m_ready      = '0;
        for (int i = 0; i < SLOTS; i++) begin
            m_cnt[i] = 0;
        end
        mask_on      = 1'b0;
        mask_id      = '0;
        have_req     = 1'b0;
        cur_req      = '0;
        cur_idx      = 0;
        saw_stall    = 1'b0;
        hs_count     = 0;
        disp_count   = 0;
        commit_count = 0;
        val_errors   = 0;
        other_errors = 0;
        timed_out    = 1'b0;
        rnd          = 32'd79492;
        $readmemh("issue_vectors.txt", vec_mem);
        repeat (4) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        check_bit("commit_o.valid after reset", 1'b0, commit_o.valid);
        for (int idx = 0; idx < VEC_NUM && !timed_out; idx++) begin
            if (idx == HAZARD_NUM) begin
                wait_drain();   // burst starts from an empty table
            end
            if (idx < HAZARD_NUM) begin
                rnd = lcg_next(rnd);
                gap = int'((rnd >> 16) & 32'd1);
                repeat (gap) begin
                    @(posedge clk);
                    #0.5;
                end
            end
            if (!timed_out) begin
                send_word(vec_mem[idx][31:0]);
            end
        end
        if (!timed_out) begin
            wait_drain();
        end
        if (!timed_out && (disp_count != VEC_NUM || commit_count != VEC_NUM)) begin
            $display("lost instructions: %0d words, %0d dispatched, %0d committed",
                     VEC_NUM, disp_count, commit_count);
            other_errors++;
        end
        $display("errors: %0d value, %0d other, timeout %0b", val_errors, other_errors,
                 timed_out);
        if (val_errors == 0 && other_errors == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* issue_vectors.txt */
// column 1: expected stall flag (1 = request must stall), column 2: 32-bit instruction word
// words 0..7 directed hazards, words 8..16 independent div burst
0_023140B3
1_02508233
0_00838333
0_00530493
0_02E6C633
1_03078633
0_03288633
1_30061A73
0_02004AB3
0_02004B33
0_02004BB3
0_02004C33
0_02004CB3
0_02004D33
0_02004DB3
0_02004E33
0_02004EB3

/* list.f */
core_cfg_pkg.sv
issue_pkg.sv
issue_decoder.sv
long_op_scoreboard.sv
long_op_exec.sv
issue_top.sv
issue_assertions.sv
tb_issue_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the issue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_issue_top -o sim_issue
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_issue)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1
